// ==== logic/chip_cfg_pkg.sv ====
// Chip configuration
// Register map of the PRCI and GPIO blocks, reset hold time and pad count
// for the reduced chip top level

`default_nettype none

package chip_cfg_pkg;

  // Pads on the GPIO bank
  localparam int GPIO_WIDTH = 12;

  // System reset hold after synchronized PLL lock
  localparam int RESET_HOLD_CYCLES = 8;
  localparam int HOLD_CNT_WIDTH = $clog2(RESET_HOLD_CYCLES + 1);

  // PRCI register offsets
  localparam logic [7:0] ADDR_PRCI_STATUS = 8'h00;
  localparam logic [7:0] ADDR_PRCI_CTRL = 8'h04;

  // GPIO register offsets
  localparam logic [7:0] ADDR_GPIO_IN = 8'h10;
  localparam logic [7:0] ADDR_GPIO_OUT = 8'h14;
  localparam logic [7:0] ADDR_GPIO_DIR = 8'h18;

  // PRCI status bit positions
  localparam int STAT_PLL_LOCK = 0;
  localparam int STAT_DDR_CALIB = 1;
  localparam int STAT_SYS_RST = 2;
  localparam int STAT_DBG_RST = 3;

endpackage

`default_nettype wire

// ==== logic/reg_bus_pkg.sv ====
// Register bus types
// Address, data and pad vectors of the register path, plus the state
// encoding of the reset sequencer

`default_nettype none

package reg_bus_pkg;

  // Register byte address
  typedef logic [7:0] reg_addr_t;

  // Register data word
  typedef logic [31:0] reg_data_t;

  // One bit per GPIO pad
  typedef logic [chip_cfg_pkg::GPIO_WIDTH-1:0] gpio_vec_t;

  // Reset sequencer states
  typedef enum logic [1:0] {
    RST_WAIT_LOCK,
    RST_HOLD,
    RST_RUN
  } rst_state_t;

endpackage

`default_nettype wire

// ==== logic/prci_ctrl.sv ====
// PLL and reset control
// Synchronizes PLL lock and DDR calibration, sequences the debug and
// system resets and serves the PRCI status and soft-reset registers

`timescale 1ns/1ps
`default_nettype none

module prci_ctrl (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_pll_locked,
  input  logic                   i_ddr_calib_done,
  input  logic                   i_sel,
  input  logic                   i_write,
  input  reg_bus_pkg::reg_addr_t i_addr,
  input  reg_bus_pkg::reg_data_t i_wdata,
  output reg_bus_pkg::reg_data_t o_rdata,
  output logic                   o_sys_rst,
  output logic                   o_dbg_rst
);

  import reg_bus_pkg::*;
  import chip_cfg_pkg::*;

  logic [1:0] lock_sync;
  logic [1:0] calib_sync;
  logic lock_s;
  logic calib_s;
  logic soft_rst_req;
  logic dbg_rst_q;

  rst_state_t state;
  rst_state_t state_next;
  logic [HOLD_CNT_WIDTH-1:0] hold_cnt;
  logic [HOLD_CNT_WIDTH-1:0] hold_cnt_next;

  reg_data_t status;

  // Two-flop synchronizers for the lock and calibration flags
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      lock_sync <= 2'b00;
      calib_sync <= 2'b00;
    end else begin
      lock_sync <= {lock_sync[0], i_pll_locked};
      calib_sync <= {calib_sync[0], i_ddr_calib_done};
    end
  end

  assign lock_s = lock_sync[1];
  assign calib_s = calib_sync[1];

  // Soft reset request from a control register write
  assign soft_rst_req = i_sel && i_write && (i_addr == ADDR_PRCI_CTRL) && i_wdata[0];

  // Reset sequencer
  always_comb begin
    state_next = state;
    hold_cnt_next = hold_cnt;
    unique case (state)
      RST_WAIT_LOCK: begin
        if (lock_s) begin
          state_next = RST_HOLD;
          hold_cnt_next = '0;
        end
      end
      RST_HOLD: begin
        if (!lock_s) begin
          state_next = RST_WAIT_LOCK;
        end else if (soft_rst_req) begin
          hold_cnt_next = '0;
        end else if (hold_cnt == HOLD_CNT_WIDTH'(RESET_HOLD_CYCLES - 1)) begin
          state_next = RST_RUN;
        end else begin
          hold_cnt_next = hold_cnt + 1'b1;
        end
      end
      RST_RUN: begin
        if (!lock_s) begin
          state_next = RST_WAIT_LOCK;
        end else if (soft_rst_req) begin
          // Lock still present, so restart the hold count
          state_next = RST_HOLD;
          hold_cnt_next = '0;
        end
      end
      default: begin
        state_next = RST_WAIT_LOCK;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= RST_WAIT_LOCK;
      hold_cnt <= '0;
      dbg_rst_q <= 1'b1;
    end else begin
      state <= state_next;
      hold_cnt <= hold_cnt_next;
      // Debug reset follows lock only
      dbg_rst_q <= !lock_s;
    end
  end

  assign o_sys_rst = (state != RST_RUN);
  assign o_dbg_rst = dbg_rst_q;

  // Status word
  always_comb begin
    status = '0;
    status[STAT_PLL_LOCK] = lock_s;
    status[STAT_DDR_CALIB] = calib_s;
    status[STAT_SYS_RST] = o_sys_rst;
    status[STAT_DBG_RST] = dbg_rst_q;
  end

  // Control register reads back as zero
  always_comb begin
    unique case (i_addr)
      ADDR_PRCI_STATUS: o_rdata = status;
      default:          o_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/gpio_regs.sv ====
// GPIO register block
// Output and direction registers, cleared by power or system reset, and a
// two-flop sampler of the pad levels behind the input register

`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_sys_rst,
  input  logic                   i_sel,
  input  logic                   i_write,
  input  reg_bus_pkg::reg_addr_t i_addr,
  input  reg_bus_pkg::reg_data_t i_wdata,
  input  reg_bus_pkg::gpio_vec_t i_pad_in,
  output reg_bus_pkg::reg_data_t o_rdata,
  output reg_bus_pkg::gpio_vec_t o_pad_out,
  output reg_bus_pkg::gpio_vec_t o_pad_dir
);

  import reg_bus_pkg::*;
  import chip_cfg_pkg::*;

  gpio_vec_t out_q;
  gpio_vec_t dir_q;
  gpio_vec_t in_meta;
  gpio_vec_t in_q;
  logic out_wr;
  logic dir_wr;

  assign out_wr = i_sel && i_write && (i_addr == ADDR_GPIO_OUT);
  assign dir_wr = i_sel && i_write && (i_addr == ADDR_GPIO_DIR);

  // Output and direction registers
  always_ff @(posedge i_clk) begin
    if (i_reset || i_sys_rst) begin
      out_q <= '0;
      dir_q <= '0;
    end else begin
      if (out_wr) begin
        out_q <= i_wdata[GPIO_WIDTH-1:0];
      end
      if (dir_wr) begin
        dir_q <= i_wdata[GPIO_WIDTH-1:0];
      end
    end
  end

  // Pad level sampler
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      in_meta <= '0;
      in_q <= '0;
    end else begin
      in_meta <= i_pad_in;
      in_q <= in_meta;
    end
  end

  assign o_pad_out = out_q;
  assign o_pad_dir = dir_q;

  // Read mux, upper bits are zero
  always_comb begin
    o_rdata = '0;
    unique case (i_addr)
      ADDR_GPIO_IN:  o_rdata[GPIO_WIDTH-1:0] = in_q;
      ADDR_GPIO_OUT: o_rdata[GPIO_WIDTH-1:0] = out_q;
      ADDR_GPIO_DIR: o_rdata[GPIO_WIDTH-1:0] = dir_q;
      default:       o_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/reg_bus_decoder.sv ====
// Register bus decoder
// Accepts one request at a time, strobes the PRCI or GPIO block and holds
// the registered response until the requester takes it

`timescale 1ns/1ps
`default_nettype none

module reg_bus_decoder (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_req_valid,
  output logic                   o_req_ready,
  input  logic                   i_req_write,
  input  reg_bus_pkg::reg_addr_t i_req_addr,
  input  reg_bus_pkg::reg_data_t i_req_wdata,
  output logic                   o_rsp_valid,
  input  logic                   i_rsp_ready,
  output reg_bus_pkg::reg_data_t o_rsp_rdata,
  output logic                   o_rsp_err,
  input  reg_bus_pkg::reg_data_t i_prci_rdata,
  input  reg_bus_pkg::reg_data_t i_gpio_rdata,
  output logic                   o_prci_sel,
  output logic                   o_gpio_sel,
  output logic                   o_write,
  output reg_bus_pkg::reg_addr_t o_addr,
  output reg_bus_pkg::reg_data_t o_wdata
);

  import reg_bus_pkg::*;
  import chip_cfg_pkg::*;

  logic req_fire;
  logic prci_hit;
  logic gpio_hit;
  reg_data_t rd_mux;

  logic rsp_valid_q;
  reg_data_t rsp_rdata_q;
  logic rsp_err_q;

  // Only one request in flight
  assign o_req_ready = !rsp_valid_q;
  assign req_fire = i_req_valid && o_req_ready;

  // Address map
  always_comb begin
    prci_hit = (i_req_addr == ADDR_PRCI_STATUS) || (i_req_addr == ADDR_PRCI_CTRL);
    gpio_hit = (i_req_addr == ADDR_GPIO_IN) ||
               (i_req_addr == ADDR_GPIO_OUT) ||
               (i_req_addr == ADDR_GPIO_DIR);
  end

  // Target strobes, one cycle per accepted request
  assign o_prci_sel = req_fire && prci_hit;
  assign o_gpio_sel = req_fire && gpio_hit;
  assign o_write = i_req_write;
  assign o_addr = i_req_addr;
  assign o_wdata = i_req_wdata;

  // Writes and misses return zero data
  always_comb begin
    if (i_req_write) begin
      rd_mux = '0;
    end else if (prci_hit) begin
      rd_mux = i_prci_rdata;
    end else if (gpio_hit) begin
      rd_mux = i_gpio_rdata;
    end else begin
      rd_mux = '0;
    end
  end

  // Response slot handshake
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (i_rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Payload loads only on accept and holds under back-pressure
  always_ff @(posedge i_clk) begin
    if (req_fire) begin
      rsp_rdata_q <= rd_mux;
      rsp_err_q <= !(prci_hit || gpio_hit);
    end
  end

  assign o_rsp_valid = rsp_valid_q;
  assign o_rsp_rdata = rsp_rdata_q;
  assign o_rsp_err = rsp_err_q;

endmodule

`default_nettype wire

// ==== logic/chip_top.sv ====
// Reduced chip top level
// Register bus decoder with PRCI and GPIO blocks behind it, reset outputs
// and the bidirectional GPIO pad loop

`timescale 1ns/1ps
`default_nettype none

module chip_top (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_pll_locked,
  input  logic                   i_ddr_calib_done,
  input  logic                   i_req_valid,
  output logic                   o_req_ready,
  input  logic                   i_req_write,
  input  reg_bus_pkg::reg_addr_t i_req_addr,
  input  reg_bus_pkg::reg_data_t i_req_wdata,
  output logic                   o_rsp_valid,
  input  logic                   i_rsp_ready,
  output reg_bus_pkg::reg_data_t o_rsp_rdata,
  output logic                   o_rsp_err,
  inout  wire reg_bus_pkg::gpio_vec_t io_gpio,
  output logic                   o_sys_rst,
  output logic                   o_dbg_rst
);

  import reg_bus_pkg::*;
  import chip_cfg_pkg::*;

  logic prci_sel;
  logic gpio_sel;
  logic bus_write;
  reg_addr_t bus_addr;
  reg_data_t bus_wdata;
  reg_data_t prci_rdata;
  reg_data_t gpio_rdata;

  gpio_vec_t pad_out;
  gpio_vec_t pad_dir;
  gpio_vec_t pad_in;

  reg_bus_decoder u_decoder (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_req_valid(i_req_valid), .o_req_ready(o_req_ready),
    .i_req_write(i_req_write), .i_req_addr(i_req_addr), .i_req_wdata(i_req_wdata),
    .o_rsp_valid(o_rsp_valid), .i_rsp_ready(i_rsp_ready),
    .o_rsp_rdata(o_rsp_rdata), .o_rsp_err(o_rsp_err),
    .i_prci_rdata(prci_rdata), .i_gpio_rdata(gpio_rdata),
    .o_prci_sel(prci_sel), .o_gpio_sel(gpio_sel),
    .o_write(bus_write), .o_addr(bus_addr), .o_wdata(bus_wdata)
  );

  // PLL and reset control
  prci_ctrl u_prci (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_pll_locked(i_pll_locked), .i_ddr_calib_done(i_ddr_calib_done),
    .i_sel(prci_sel), .i_write(bus_write), .i_addr(bus_addr), .i_wdata(bus_wdata),
    .o_rdata(prci_rdata), .o_sys_rst(o_sys_rst), .o_dbg_rst(o_dbg_rst)
  );

  gpio_regs u_gpio (
    .i_clk(i_clk), .i_reset(i_reset), .i_sys_rst(o_sys_rst),
    .i_sel(gpio_sel), .i_write(bus_write), .i_addr(bus_addr), .i_wdata(bus_wdata),
    .i_pad_in(pad_in), .o_rdata(gpio_rdata),
    .o_pad_out(pad_out), .o_pad_dir(pad_dir)
  );

  // Pad buffers, high impedance unless direction bit set
  genvar i;
  generate
    for (i = 0; i < GPIO_WIDTH; i++) begin : g_pad
      assign io_gpio[i] = pad_dir[i] ? pad_out[i] : 1'bz;
    end
  endgenerate

  // Pad levels loop back as inputs
  assign pad_in = io_gpio;

endmodule

`default_nettype wire

// ==== verification/chip_top_chk.sv ====
// Register bus and reset checker
// Concurrent assertions on the response handshake, the reset outputs and
// the GPIO pad drivers, bound into the chip top level

`timescale 1ns/1ps
`default_nettype none

module chip_top_chk (
  input logic                   i_clk,
  input logic                   i_reset,
  input logic                   i_req_valid,
  input logic                   i_req_ready,
  input logic                   i_rsp_valid,
  input logic                   i_rsp_ready,
  input reg_bus_pkg::reg_data_t i_rsp_rdata,
  input logic                   i_rsp_err,
  input logic                   i_sys_rst,
  input logic                   i_dbg_rst,
  input reg_bus_pkg::gpio_vec_t i_pad_dir
);

  // Accepted request answers on the next cycle and blocks new requests
  a_accept_rsp: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_req_valid && i_req_ready) |=> (i_rsp_valid && !i_req_ready))
    else $error("No pending response in the cycle after a request was accepted");

  // Stalled response keeps its payload
  a_rsp_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_rsp_valid && !i_rsp_ready) |=>
      (i_rsp_valid && $stable(i_rsp_rdata) && $stable(i_rsp_err)))
    else $error("Response changed while held by back-pressure");

  a_rst_order: assert property (@(posedge i_clk) disable iff (i_reset)
    i_dbg_rst |-> i_sys_rst)
    else $error("Debug reset active while system reset is released");

  // Pads float during power reset
  a_pads_off: assert property (@(posedge i_clk)
    (i_reset && $past(i_reset)) |-> (i_pad_dir == '0))
    else $error("GPIO pad driven during reset");

endmodule

bind chip_top chip_top_chk u_chk (
  .i_clk(i_clk),
  .i_reset(i_reset),
  .i_req_valid(i_req_valid),
  .i_req_ready(o_req_ready),
  .i_rsp_valid(o_rsp_valid),
  .i_rsp_ready(i_rsp_ready),
  .i_rsp_rdata(o_rsp_rdata),
  .i_rsp_err(o_rsp_err),
  .i_sys_rst(o_sys_rst),
  .i_dbg_rst(o_dbg_rst),
  .i_pad_dir(pad_dir)
);

`default_nettype wire

// ==== verification/chip_top_tb.sv ====
// Testbench for the reduced chip top level
// Directed tests of reset sequencing, GPIO output and input, soft reset,
// loss of lock, error responses and response back-pressure

`timescale 1ns/1ps
`default_nettype none

module chip_top_tb;

  import reg_bus_pkg::*;
  import chip_cfg_pkg::*;

  localparam int WAIT_LIMIT = 200;

  logic i_clk;
  logic i_reset;
  logic i_pll_locked;
  logic i_ddr_calib_done;
  logic i_req_valid;
  logic o_req_ready;
  logic i_req_write;
  reg_addr_t i_req_addr;
  reg_data_t i_req_wdata;
  logic o_rsp_valid;
  logic i_rsp_ready;
  reg_data_t o_rsp_rdata;
  logic o_rsp_err;
  logic o_sys_rst;
  logic o_dbg_rst;
  wire gpio_vec_t io_gpio;

  // Expected register contents and testbench pad levels
  gpio_vec_t exp_out;
  gpio_vec_t exp_dir;
  gpio_vec_t dir_model;
  gpio_vec_t pad_levels;
  integer seed;
  int error_count;

  chip_top i_chip_top (.*);

  // External pad drivers stay off wherever the DUT may drive
  genvar g;
  generate
    for (g = 0; g < GPIO_WIDTH; g++) begin : g_pad_drv
      assign io_gpio[g] = dir_model[g] ? 1'bz : pad_levels[g];
    end
  endgenerate

  always #50 i_clk = ~i_clk;

  task automatic report_failure(input string msg);
    error_count++;
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_data(input reg_data_t got, input reg_data_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at time %0t: %s, got %h expected %h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_gpio(input gpio_vec_t got, input gpio_vec_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at time %0t: %s, got %h expected %h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at time %0t: %s, got %b expected %b",
                               $time, what, got, exp));
    end
  endtask

  function automatic gpio_vec_t random_pads();
    return gpio_vec_t'($random(seed));
  endfunction

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  // Poll both reset outputs until they reach the given levels
  task automatic wait_resets(input logic exp_sys, input logic exp_dbg, input string what);
    int n;
    n = 0;
    while (o_sys_rst !== exp_sys || o_dbg_rst !== exp_dbg) begin
      if (n == WAIT_LIMIT) begin
        report_failure($sformatf("Timed out waiting for %s", what));
      end
      idle(1);
      n++;
    end
  endtask

  task automatic send_request(input logic wr, input reg_addr_t addr, input reg_data_t wdata);
    int n;
    n = 0;
    i_req_valid = 1'b1;
    i_req_write = wr;
    i_req_addr = addr;
    i_req_wdata = wdata;
    while (o_req_ready !== 1'b1) begin
      if (n == WAIT_LIMIT) begin
        report_failure("Timed out waiting for the bus to accept a request");
      end
      idle(1);
      n++;
    end
    // Ready is high, so the next edge takes the request
    idle(1);
    i_req_valid = 1'b0;
  endtask

  task automatic wait_response(output reg_data_t rdata, output logic err);
    int n;
    n = 0;
    while (o_rsp_valid !== 1'b1) begin
      if (n == WAIT_LIMIT) begin
        report_failure("Timed out waiting for a bus response");
      end
      idle(1);
      n++;
    end
    rdata = o_rsp_rdata;
    err = o_rsp_err;
  endtask

  task automatic bus_read(input reg_addr_t addr, output reg_data_t rdata, output logic err);
    send_request(1'b0, addr, '0);
    wait_response(rdata, err);
    idle(1);
  endtask

  task automatic bus_write(input reg_addr_t addr, input reg_data_t wdata, output logic err);
    reg_data_t unused_rdata;
    send_request(1'b1, addr, wdata);
    wait_response(unused_rdata, err);
    idle(1);
  endtask

  task automatic read_and_compare(input reg_addr_t addr, input reg_data_t exp,
                                  input string what);
    reg_data_t rd;
    logic err;
    bus_read(addr, rd, err);
    check_bit(err, 1'b0, {what, " error flag"});
    check_data(rd, exp, what);
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t wdata, input string what);
    logic err;
    bus_write(addr, wdata, err);
    check_bit(err, 1'b0, {what, " error flag"});
  endtask

  // Stop driving pads the DUT is about to take over before the write
  task automatic set_direction(input gpio_vec_t dir);
    dir_model = dir_model | dir;
    write_reg(ADDR_GPIO_DIR, reg_data_t'(dir), "GPIO dir write");
    dir_model = dir;
    exp_dir = dir;
  endtask

  task automatic test_reset_outputs();
    check_bit(o_rsp_valid, 1'b0, "response valid during reset");
    check_bit(o_req_ready, 1'b1, "request ready during reset");
    check_bit(o_sys_rst, 1'b1, "system reset during reset");
    check_bit(o_dbg_rst, 1'b1, "debug reset during reset");
    check_gpio(io_gpio, pad_levels, "pad levels during reset");
  endtask

  task automatic test_reset_sequence();
    check_bit(o_sys_rst, 1'b1, "system reset before lock");
    check_bit(o_dbg_rst, 1'b1, "debug reset before lock");
    read_and_compare(ADDR_PRCI_STATUS, {28'b0, 4'b1100}, "status before lock");
    i_pll_locked = 1'b1;
    wait_resets(1'b1, 1'b0, "debug reset release");
    wait_resets(1'b0, 1'b0, "system reset release");
    read_and_compare(ADDR_PRCI_STATUS, {28'b0, 4'b0001}, "status after lock");
    // Calibration flag crosses a two-flop synchronizer
    i_ddr_calib_done = 1'b1;
    idle(3);
    read_and_compare(ADDR_PRCI_STATUS, {28'b0, 4'b0011}, "status after calibration");
  endtask

  task automatic test_gpio_output();
    exp_out = random_pads();
    write_reg(ADDR_GPIO_OUT, reg_data_t'(exp_out), "GPIO out write");
    set_direction(random_pads());
    read_and_compare(ADDR_GPIO_OUT, reg_data_t'(exp_out), "GPIO out readback");
    read_and_compare(ADDR_GPIO_DIR, reg_data_t'(exp_dir), "GPIO dir readback");
    check_gpio(io_gpio & exp_dir, exp_out & exp_dir, "driven pad levels");
  endtask

  task automatic test_gpio_input();
    gpio_vec_t exp_in;
    pad_levels = random_pads();
    exp_in = (exp_out & exp_dir) | (pad_levels & ~exp_dir);
    idle(3);
    read_and_compare(ADDR_GPIO_IN, reg_data_t'(exp_in), "GPIO input levels");
  endtask

  task automatic test_soft_reset();
    write_reg(ADDR_PRCI_CTRL, 32'h1, "soft reset write");
    check_bit(o_sys_rst, 1'b1, "system reset after soft reset");
    check_bit(o_dbg_rst, 1'b0, "debug reset after soft reset");
    // System reset has cleared the GPIO registers by now
    exp_out = '0;
    exp_dir = '0;
    dir_model = '0;
    wait_resets(1'b0, 1'b0, "system reset release after soft reset");
    check_bit(o_dbg_rst, 1'b0, "debug reset after soft reset release");
    read_and_compare(ADDR_GPIO_OUT, '0, "GPIO out after soft reset");
    read_and_compare(ADDR_GPIO_DIR, '0, "GPIO dir after soft reset");
    read_and_compare(ADDR_PRCI_CTRL, '0, "control register readback");
  endtask

  task automatic test_lock_loss();
    i_pll_locked = 1'b0;
    wait_resets(1'b1, 1'b1, "both resets after lock loss");
    read_and_compare(ADDR_PRCI_STATUS, {28'b0, 4'b1110}, "status without lock");
    i_pll_locked = 1'b1;
    wait_resets(1'b1, 1'b0, "debug reset release after relock");
    wait_resets(1'b0, 1'b0, "system reset release after relock");
  endtask

  task automatic test_error_and_backpressure();
    reg_data_t rd;
    logic err;
    bus_read(8'h40, rd, err);
    check_bit(err, 1'b1, "unmapped read error flag");
    check_data(rd, '0, "unmapped read data");
    bus_write(8'h24, 32'hA5A5_0001, err);
    check_bit(err, 1'b1, "unmapped write error flag");
    read_and_compare(ADDR_PRCI_STATUS, {28'b0, 4'b0011}, "mapped status read");
    set_direction(random_pads());
    // Hold off the response and watch it stay put
    i_rsp_ready = 1'b0;
    send_request(1'b0, ADDR_GPIO_DIR, '0);
    wait_response(rd, err);
    check_data(rd, reg_data_t'(exp_dir), "stalled read data");
    check_bit(err, 1'b0, "stalled read error flag");
    repeat (5) begin
      idle(1);
      check_bit(o_rsp_valid, 1'b1, "response valid under back-pressure");
      check_data(o_rsp_rdata, reg_data_t'(exp_dir), "response data under back-pressure");
      check_bit(o_rsp_err, 1'b0, "response error under back-pressure");
      check_bit(o_req_ready, 1'b0, "request ready under back-pressure");
    end
    i_rsp_ready = 1'b1;
    idle(1);
    check_bit(o_rsp_valid, 1'b0, "response valid after release");
    check_bit(o_req_ready, 1'b1, "request ready after release");
  endtask

  initial begin : watchdog
    #1_000_000;
    report_failure("Simulation ran past its time limit");
  end

  initial begin
    seed = 54598;
    error_count = 0;
    i_clk = 1'b0;
    i_reset = 1'b1;
    i_pll_locked = 1'b0;
    i_ddr_calib_done = 1'b0;
    i_req_valid = 1'b0;
    i_req_write = 1'b0;
    i_req_addr = '0;
    i_req_wdata = '0;
    i_rsp_ready = 1'b1;
    exp_out = '0;
    exp_dir = '0;
    dir_model = '0;
    pad_levels = random_pads();
    repeat (3) @(posedge i_clk);
    #1;
    test_reset_outputs();
    i_reset = 1'b0;
    test_reset_sequence();
    test_gpio_output();
    test_gpio_input();
    test_soft_reset();
    test_lock_loss();
    test_error_and_backpressure();
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
logic/chip_cfg_pkg.sv
logic/reg_bus_pkg.sv
logic/prci_ctrl.sv
logic/gpio_regs.sv
logic/reg_bus_decoder.sv
logic/chip_top.sv
verification/chip_top_chk.sv
verification/chip_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the chip_top testbench with Verilator and run it
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module chip_top_tb -f files.f -o chip_top_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/chip_top_sim > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Test completed successfully" sim.log \
  || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
exit 0
